/* hdl/nnPkg.sv */
package nnPkg;

	localparam int dataWidth = 16;

	typedef logic [dataWidth-1:0] activation;

	localparam int inputCount = 15;
	localparam int hiddenCount = 4;
	localparam int classCount = 3;

	typedef logic [inputCount*dataWidth-1:0] inputVector;
	typedef logic [hiddenCount*dataWidth-1:0] hiddenVector;
	typedef logic [classCount*dataWidth-1:0] classVector;
	typedef logic [1:0] classIndex;

	// Indexed by layer number, 0 = hidden and 1 = output.
	localparam int layerInputs [2] = '{inputCount, hiddenCount};
	localparam int layerSize [2] = '{hiddenCount, classCount};

	localparam activation hiddenWeights [hiddenCount][inputCount] = '{
		'{
			16'sd62, 16'sd35, 16'sd11, -16'sd19, -16'sd20,
			-16'sd3, 16'sd7, 16'sd30, -16'sd10, -16'sd33,
			-16'sd17, -16'sd35, 16'sd6, 16'sd62, 16'sd11
		},
		'{
			-16'sd14, 16'sd27, 16'sd40, 16'sd9, -16'sd6,
			16'sd18, -16'sd25, 16'sd3, 16'sd51, -16'sd8,
			16'sd12, 16'sd22, -16'sd31, 16'sd5, -16'sd2
		},
		'{
			16'sd8, -16'sd41, 16'sd19, 16'sd33, 16'sd26,
			-16'sd12, 16'sd4, -16'sd17, 16'sd0, 16'sd44,
			16'sd9, -16'sd5, 16'sd28, -16'sd23, 16'sd15
		},
		'{
			16'sd21, 16'sd6, -16'sd28, -16'sd11, 16'sd37,
			16'sd14, 16'sd55, -16'sd9, 16'sd20, 16'sd3,
			-16'sd46, 16'sd10, 16'sd17, 16'sd2, -16'sd30
		}
	};

	localparam activation hiddenBias [hiddenCount] = '{
		16'sd16,
		-16'sd8,
		16'sd32,
		16'sd0
	};

	localparam activation outputWeights [classCount][hiddenCount] = '{
		'{16'sd12, -16'sd7, 16'sd25, 16'sd3},
		'{-16'sd4, 16'sd18, 16'sd9, 16'sd21},
		'{16'sd15, 16'sd11, -16'sd13, 16'sd7}
	};

	localparam activation outputBias [classCount] = '{
		16'sd5,
		-16'sd3,
		16'sd10
	};

	localparam int neuronLatency = 3;
	localparam int argmaxLatency = 1;
	localparam int totalLatency = 2 * neuronLatency + argmaxLatency;

	// Weight of one input of one neuron in either layer.
	function automatic activation weightOf(input int layer, input int neuron, input int idx);
		activation value;
		if (layer == 0)
		begin
			value = hiddenWeights[neuron][idx];
		end
		else
		begin
			value = outputWeights[neuron][idx];
		end
		return value;
	endfunction

	function automatic activation biasOf(input int layer, input int neuron);
		activation value;
		if (layer == 0)
		begin
			value = hiddenBias[neuron];
		end
		else
		begin
			value = outputBias[neuron];
		end
		return value;
	endfunction

endpackage

/* hdl/denseNeuron.sv */
`timescale 1ns/10ps

module denseNeuron #(
	parameter int layerSel = 0,
	parameter int neuronIndex = 0
) (
	input logic clk,
	input logic reset,
	input logic [nnPkg::layerInputs[layerSel]*nnPkg::dataWidth-1:0] activations,
	output nnPkg::activation result
);
	import nnPkg::*;

	localparam int fanIn = layerInputs[layerSel];
	localparam activation bias = biasOf(layerSel, neuronIndex);

	activation inReg [fanIn];
	activation products [fanIn];
	activation sumNext;
	activation sumReg;

	// Stage 1 holds the incoming vector.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < fanIn; i++)
			begin
				inReg[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < fanIn; i++)
			begin
				inReg[i] <= activations[i*dataWidth +: dataWidth];
			end
		end
	end

	for (genvar i = 0; i < fanIn; i++)
	begin : genProduct
		localparam activation weight = weightOf(layerSel, neuronIndex, i);

		assign products[i] = inReg[i] * weight; // Low half of the product.
	end

	always_comb
	begin
		sumNext = bias;
		for (int i = 0; i < fanIn; i++)
		begin
			sumNext = sumNext + products[i]; // Wraps at 16 bits.
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			sumReg <= sumNext;
			if (sumReg[dataWidth-1] == 1'b0)
			begin
				result <= sumReg;
			end
			else
			begin
				result <= '0; // ReLU.
			end
		end
	end

endmodule

/* hdl/denseLayer.sv */
`timescale 1ns/10ps

module denseLayer #(
	parameter int layerSel = 0
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic [nnPkg::layerInputs[layerSel]*nnPkg::dataWidth-1:0] activations,
	output logic outValid,
	output logic [nnPkg::layerSize[layerSel]*nnPkg::dataWidth-1:0] results
);
	import nnPkg::*;

	localparam int neuronCount = layerSize[layerSel];

	logic [neuronLatency-1:0] validPipe;
	activation neuronOut [neuronCount];

	// Strobe travels alongside the neuron stages.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[neuronLatency-2:0], inValid};
		end
	end

	assign outValid = validPipe[neuronLatency-1];

	for (genvar n = 0; n < neuronCount; n++)
	begin : genNeuron
		denseNeuron #(
			.layerSel(layerSel),
			.neuronIndex(n)
		) neuron (
			.clk(clk),
			.reset(reset),
			.activations(activations), // Same vector to every neuron.
			.result(neuronOut[n])
		);
	end

	always_comb
	begin
		results = '0;
		for (int n = 0; n < neuronCount; n++)
		begin
			results[n*dataWidth +: dataWidth] = neuronOut[n];
		end
	end

endmodule

/* hdl/argmaxSelect.sv */
`timescale 1ns/10ps

module argmaxSelect (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::classVector scoresIn,
	output logic outValid,
	output nnPkg::classVector scoresOut,
	output nnPkg::classIndex bestClass,
	output nnPkg::activation bestScore
);
	import nnPkg::*;

	activation score [classCount];
	classIndex pickIndex;
	activation pickScore;

	// Scores are post-ReLU, so unsigned compares are enough.
	always_comb
	begin
		for (int c = 0; c < classCount; c++)
		begin
			score[c] = scoresIn[c*dataWidth +: dataWidth];
		end
		pickIndex = '0;
		pickScore = score[0];
		for (int c = 1; c < classCount; c++)
		begin
			if (score[c] > pickScore) // Strict, lower index keeps ties.
			begin
				pickIndex = classIndex'(c);
				pickScore = score[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			outValid <= 1'b0;
			scoresOut <= '0;
			bestClass <= '0;
			bestScore <= '0;
		end
		else
		begin
			outValid <= inValid;
			scoresOut <= scoresIn;
			bestClass <= pickIndex;
			bestScore <= pickScore;
		end
	end

endmodule

/* hdl/nnClassifier.sv */
`timescale 1ns/10ps

module nnClassifier (
	input logic clk,
	input logic reset,
	input logic inValid,
	input nnPkg::inputVector features,
	output logic outValid,
	output nnPkg::classIndex bestClass,
	output nnPkg::activation bestScore,
	output nnPkg::classVector scores
);
	import nnPkg::*;

	logic hiddenValid;
	hiddenVector hiddenActs;
	logic classValid;
	classVector classActs;

	denseLayer #(
		.layerSel(0)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.activations(features),
		.outValid(hiddenValid),
		.results(hiddenActs)
	);

	denseLayer #(
		.layerSel(1)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.activations(hiddenActs),
		.outValid(classValid),
		.results(classActs)
	);

	// Final stage, registers the winner with the raw scores.
	argmaxSelect selector (
		.clk(clk),
		.reset(reset),
		.inValid(classValid),
		.scoresIn(classActs),
		.outValid(outValid),
		.scoresOut(scores),
		.bestClass(bestClass),
		.bestScore(bestScore)
	);

endmodule

/* test/nnClassifier_checker.sv */
`timescale 1ns/10ps

module nnClassifier_checker (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic outValid,
	input nnPkg::classIndex bestClass,
	input nnPkg::activation bestScore
);
	import nnPkg::*;

	// Every strobe comes out after the full pipeline.
	assert property (@(posedge clk) disable iff (reset)
		inValid |-> ##totalLatency outValid)
		else $error("outValid missing %0d cycles after inValid", totalLatency);

	assert property (@(posedge clk) disable iff (reset)
		outValid |-> $past(inValid, totalLatency))
		else $error("outValid without a matching inValid");

	assert property (@(posedge clk) reset |=> !outValid)
		else $error("outValid high during reset");

	assert property (@(posedge clk) disable iff (reset)
		outValid |-> bestClass < classCount)
		else $error("bestClass out of range");

	// Scores are post-ReLU.
	assert property (@(posedge clk) disable iff (reset)
		outValid |-> !bestScore[dataWidth-1])
		else $error("bestScore is negative");

endmodule

bind nnClassifier nnClassifier_checker strobeChecks (
	.clk(clk),
	.reset(reset),
	.inValid(inValid),
	.outValid(outValid),
	.bestClass(bestClass),
	.bestScore(bestScore)
);

/* test/nnClassifierTb.sv */
`timescale 1ns/10ps

module nnClassifierTb;
	import nnPkg::*;

	typedef struct packed {
		classVector scores;
		classIndex bestClass;
		activation bestScore;
	} expectation;

	localparam int resetCycles = 4;
	localparam int directedCount = 1 + inputCount + 3 + 4;
	localparam int tieCount = 4;
	localparam int searchLimit = 2000;
	localparam int randomCount = 300;
	localparam int maxGap = 3;
	localparam int burstCount = 10;
	localparam int quietCycles = 10;
	localparam int afterCount = 20;
	localparam int drainLimit = totalLatency + 2;
	localparam int stimulusCycles = 2 * resetCycles + directedCount + tieCount
		+ randomCount * (maxGap + 1) + burstCount + quietCycles + afterCount + drainLimit;
	localparam int cycleLimit = stimulusCycles + totalLatency + 20;

	logic clk;
	logic reset;
	logic inValid;
	inputVector features;
	logic outValid;
	classIndex bestClass;
	activation bestScore;
	classVector scores;

	expectation expectQ [$];
	expectation popped;
	int cycleCount = 0;
	int matchedCount = 0;

	nnClassifier dut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.features(features),
		.outValid(outValid),
		.bestClass(bestClass),
		.bestScore(bestScore),
		.scores(scores)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic checkValue(input string field, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected)
		begin
			stopWithFailure($sformatf("error at %0t: %s is %0h, expected %0h",
				$time, field, actual, expected));
		end
	endtask

	// Network model with 16-bit wrapping products and sums.
	function automatic expectation referenceModel(input inputVector feat);
		activation hidden [hiddenCount];
		activation outs [classCount];
		activation acc;
		activation product;
		expectation res;
		for (int h = 0; h < hiddenCount; h++)
		begin
			acc = hiddenBias[h];
			for (int i = 0; i < inputCount; i++)
			begin
				product = feat[i*dataWidth +: dataWidth] * hiddenWeights[h][i];
				acc = acc + product;
			end
			hidden[h] = acc[dataWidth-1] ? '0 : acc;
		end
		for (int c = 0; c < classCount; c++)
		begin
			acc = outputBias[c];
			for (int h = 0; h < hiddenCount; h++)
			begin
				product = hidden[h] * outputWeights[c][h];
				acc = acc + product;
			end
			outs[c] = acc[dataWidth-1] ? '0 : acc;
		end
		res.bestClass = '0;
		res.bestScore = outs[0];
		for (int c = 1; c < classCount; c++)
		begin
			if (outs[c] > res.bestScore) // Ties stay with the lower class.
			begin
				res.bestClass = classIndex'(c);
				res.bestScore = outs[c];
			end
		end
		for (int c = 0; c < classCount; c++)
		begin
			res.scores[c*dataWidth +: dataWidth] = outs[c];
		end
		return res;
	endfunction

	function automatic int topTieCount(input expectation e);
		int count;
		count = 0;
		for (int c = 0; c < classCount; c++)
		begin
			if (e.scores[c*dataWidth +: dataWidth] == e.bestScore)
			begin
				count++;
			end
		end
		return count;
	endfunction

	function automatic inputVector rampVector(input activation start, input activation step);
		inputVector vec;
		for (int i = 0; i < inputCount; i++)
		begin
			vec[i*dataWidth +: dataWidth] = activation'(start + i * step);
		end
		return vec;
	endfunction

	// Each input pushes against the sign of its weight in one hidden row.
	function automatic inputVector opposedVector(input int row, input activation magnitude);
		inputVector vec;
		for (int i = 0; i < inputCount; i++)
		begin
			vec[i*dataWidth +: dataWidth] = hiddenWeights[row][i][dataWidth-1] ?
				magnitude : activation'(-magnitude);
		end
		return vec;
	endfunction

	function automatic inputVector randomVector(input bit fullRange);
		inputVector vec;
		int offset;
		for (int i = 0; i < inputCount; i++)
		begin
			offset = $urandom_range(400);
			vec[i*dataWidth +: dataWidth] = fullRange ?
				activation'($urandom) : activation'(offset - 200);
		end
		return vec;
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic sendVector(input inputVector vec);
		features = vec;
		inValid = 1'b1;
		expectQ.push_back(referenceModel(vec));
		nextCycle();
		inValid = 1'b0;
	endtask

	task automatic applyReset();
		reset = 1'b1;
		inValid = 1'b0;
		expectQ.delete(); // Items in flight are lost.
		repeat (resetCycles) nextCycle();
		reset = 1'b0;
	endtask

	always @(negedge clk)
	begin
		if (!reset && outValid)
		begin
			if (expectQ.size() == 0)
			begin
				stopWithFailure("Unexpected output: outValid was high with nothing pending");
			end
			else
			begin
				popped = expectQ.pop_front();
				checkValue("scores", scores, popped.scores);
				checkValue("bestClass", bestClass, popped.bestClass);
				checkValue("bestScore", bestScore, popped.bestScore);
				matchedCount++;
			end
		end
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= cycleLimit)
		begin
			stopWithFailure($sformatf("Timeout: run did not end within %0d cycles", cycleLimit));
		end
	end

	initial
	begin
		inputVector vec;
		int gap;
		int tiesFound;
		reset = 1'b1;
		inValid = 1'b0;
		features = '0;
		void'($urandom(32'h84d2));
		applyReset();

		sendVector('0); // Biases only.
		for (int i = 0; i < inputCount; i++)
		begin
			vec = '0;
			vec[i*dataWidth +: dataWidth] = activation'((i % 2 == 0) ? (i + 1) * 37 : -(i + 1) * 37);
			sendVector(vec);
		end
		sendVector(rampVector(-16'sd100, 16'sd0));
		sendVector(opposedVector(0, 16'sd50)); // Small enough that the sum stays negative.
		sendVector(opposedVector(1, 16'sd50));
		sendVector(rampVector(16'h7fff, 16'h0000)); // Overflowing products.
		sendVector(rampVector(16'h8000, 16'h0000));
		sendVector(rampVector(16'h6000, 16'h0f1d));
		sendVector(rampVector(16'h8001, 16'h7fff));

		// Hunt for vectors where the top score is shared.
		tiesFound = 0;
		for (int tries = 0; tries < searchLimit && tiesFound < tieCount; tries++)
		begin
			vec = randomVector(1'b1);
			if (topTieCount(referenceModel(vec)) > 1)
			begin
				sendVector(vec);
				tiesFound++;
			end
		end
		if (tiesFound < tieCount)
		begin
			stopWithFailure("Could not find enough input vectors with tied top scores");
		end

		for (int n = 0; n < randomCount; n++)
		begin
			sendVector(randomVector($urandom_range(1)));
			gap = $urandom_range(maxGap);
			repeat (gap) nextCycle();
		end

		for (int n = 0; n < burstCount; n++)
		begin
			sendVector(randomVector(1'b1));
		end
		applyReset();
		repeat (quietCycles) nextCycle(); // Nothing may come out here.
		for (int n = 0; n < afterCount; n++)
		begin
			sendVector(randomVector($urandom_range(1)));
		end

		for (int n = 0; n < drainLimit && expectQ.size() != 0; n++)
		begin
			nextCycle();
		end
		if (expectQ.size() != 0)
		begin
			stopWithFailure($sformatf("Missing outputs: %0d items never came out",
				expectQ.size()));
		end
		else
		begin
			$display("Compared %0d results", matchedCount);
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

/* nnClassifier.f */
hdl/nnPkg.sv
hdl/denseNeuron.sv
hdl/denseLayer.sv
hdl/argmaxSelect.sv
hdl/nnClassifier.sv
test/nnClassifier_checker.sv
test/nnClassifierTb.sv
